//--- tb_admm_input.txt
# Records: T <test name> | W <addr> <data> | R <addr> <expected> <register name>
# P <poll limit> reads status until done is set; addr, data and expected are hex
T reset_values
R 0000 00000000 status
R 0004 00000000 iter
R 0008 00000000 pri_res
R 000c 00000000 dual_res
R 4000 00000000 z0
R 4010 00000000 z4
R 401c 00000000 z7
R 5000 00000000 y0
R 5010 00000000 y4
R 501c 00000000 y7
R 6000 00000000 unmapped_region
R 0010 00000000 unmapped_ctrl
T interior_solve
W 0004 00000064
W 0008 00000002
W 000c 00000002
W 1000 00000100
W 1004 0000ff00
W 1008 00000064
W 100c 0000ffb3
W 0000 00000001
P 200
R 0000 00000003 status
R 0004 00000007 iter
R 0008 00000000 pri_res
R 000c 00000002 dual_res
R 4000 000000fe z0
R 4004 ffffff02 z1
R 4008 00000063 z2
R 400c ffffffb3 z3
R 401c 00000000 z7
R 5000 00000000 y0
R 5004 00000000 y1
T restart
W 0000 00000001
R 0000 00000004 status_busy
W 0000 00000001
R 0000 00000004 status_busy
P 200
R 0000 00000003 status
R 0004 00000007 iter
R 000c 00000002 dual_res
R 4000 000000fe z0
R 4004 ffffff02 z1
R 4008 00000063 z2
R 400c ffffffb3 z3
R 5000 00000000 y0
T clamp_solve
W 2000 0000ffc0
W 3000 00000040
W 2004 0000ffe0
W 3004 00000020
W 0000 00000001
P 200
R 0000 00000003 status
R 0004 00000007 iter
R 0008 00000002 pri_res
R 000c 00000001 dual_res
R 4000 00000040 z0
R 4004 ffffffe0 z1
R 5000 000000be y0
R 5004 ffffff22 y1
R 4008 00000063 z2
R 5008 00000000 y2
T iteration_cap
W 0004 00000003
W 0008 00000000
W 000c 00000000
W 0000 00000001
P 200
R 0000 00000001 status
R 0004 00000003 iter
R 0008 00000020 pri_res
R 000c 0000000c dual_res
R 4000 00000040 z0
R 4004 ffffffe0 z1
R 4008 00000057 z2
R 400c ffffffbc z3
R 5000 000000a0 y0
R 5004 ffffff40 y1

//--- admm_solver.f
admm_pkg.sv
admm_bus_pkg.sv
admm_config_regs.sv
admm_iter_ctrl.sv
admm_element_pipe.sv
admm_vector_store.sv
admm_readback.sv
admm_solver.sv
tb_admm_solver.sv

//--- tb_admm_solver.sv
`timescale 1ns/100ps
`default_nettype none

module tb_admm_solver;

    localparam STIM_FILE = "tb_admm_input.txt";
    localparam int CYCLES_PER_RECORD = 20;
    localparam int CYCLES_PER_POLL   = 4;
    localparam int RESET_CYCLES      = 5;

    logic        clk;
    logic        rst;
    logic        chipselect;
    logic        read;
    logic        write;
    logic [15:0] addr;
    logic [31:0] writedata;
    logic [31:0] readdata;

    int    cycle_cnt;
    int    cycle_limit;                          // Zero until the stimulus file is sized
    int    errors;
    int    checks;
    int    tests;
    int    test_errors;
    int    test_checks;
    string test_name;

    admm_solver UUT (
        .clk(clk), .rst(rst), .writedata(writedata), .read(read), .write(write),
        .addr(addr), .chipselect(chipselect), .readdata(readdata)
    );

    always #2 clk = ~clk;                        // 4 ns period

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the stimulus never finished", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // Single-cycle strobe, followed by one idle cycle
    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        @(posedge clk);
        #0.5;
        chipselect = 1'b1;
        write      = 1'b1;
        addr       = a;
        writedata  = d;
        @(posedge clk);
        #0.5;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [31:0] d);
        @(posedge clk);
        #0.5;
        chipselect = 1'b1;
        read       = 1'b1;
        addr       = a;
        @(posedge clk);
        #0.5;
        chipselect = 1'b0;
        read       = 1'b0;
        d          = readdata;                   // Registered at the strobe edge
    endtask

    task automatic check_read(input logic [15:0] a, input logic [31:0] expected,
                              input string reg_name);
        logic [31:0] got;
        bus_read(a, got);
        checks++;
        test_checks++;
        assert (got === expected)
        else begin
            $display("mismatch at %0.1f ns: %s read 0x%08h, expected 0x%08h",
                     $realtime, reg_name, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic poll_done(input int limit);
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (status[0] !== 1'b1 && polls < limit) begin
            bus_read(16'h0000, status);
            polls++;
        end
        checks++;
        test_checks++;
        assert (status[0] === 1'b1)
        else begin
            $display("solver did not set done within %0d status reads", limit);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
            tests++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // Next record of the file, comment lines skipped
    task automatic read_record(input int fd, output string kind, output logic [31:0] a,
                               output logic [31:0] d, output string text, output bit ok);
        logic [8*200-1:0] line;
        int               n;
        ok = 1'b0;
        while (!ok && $fscanf(fd, "%s", kind) == 1) begin
            if (kind[0] == "#") begin
                n = $fgets(line, fd);
            end else begin
                if (kind == "T")
                    n = $fscanf(fd, "%s", text);
                else if (kind == "W")
                    n = $fscanf(fd, "%h %h", a, d);
                else if (kind == "R")
                    n = $fscanf(fd, "%h %h %s", a, d, text);
                else if (kind == "P")
                    n = $fscanf(fd, "%d", d);
                ok = 1'b1;
            end
        end
    endtask

    initial begin
        int          fd;
        string       kind;
        string       text;
        logic [31:0] a;
        logic [31:0] d;
        bit          ok;
        int          budget;

        clk         = 1'b0;
        rst         = 1'b1;
        chipselect  = 1'b0;
        read        = 1'b0;
        write       = 1'b0;
        addr        = '0;
        writedata   = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        test_checks = 0;
        test_name   = "";
        budget      = 0;

        // First pass sizes the timeout from the records
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            read_record(fd, kind, a, d, text, ok);
            while (ok) begin
                budget += CYCLES_PER_RECORD;
                if (kind == "P")
                    budget += d * CYCLES_PER_POLL;
                read_record(fd, kind, a, d, text, ok);
            end
            $fclose(fd);
            cycle_limit = budget + RESET_CYCLES;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;

        if (cycle_limit > 0) begin
            fd = $fopen(STIM_FILE, "r");
            read_record(fd, kind, a, d, text, ok);
            while (ok) begin
                if (kind == "T") begin
                    close_test();
                    test_name = text;
                end else if (kind == "W") begin
                    bus_write(a[15:0], d);
                end else if (kind == "R") begin
                    check_read(a[15:0], d, text);
                end else if (kind == "P") begin
                    poll_done(d);
                end else begin
                    $display("unknown record kind %s in stimulus file", kind);
                    errors++;
                    test_errors++;
                end
                read_record(fd, kind, a, d, text, ok);
            end
            $fclose(fd);
            close_test();
        end

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- admm_solver.sv
`timescale 1ns/100ps
`default_nettype none

module admm_solver (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [admm_bus_pkg::BUS_WIDTH-1:0]   writedata,
    input  logic                                 read,
    input  logic                                 write,
    input  logic [admm_bus_pkg::ADDR_WIDTH-1:0]  addr,
    input  logic                                 chipselect,
    output logic [admm_bus_pkg::BUS_WIDTH-1:0]   readdata
);

    admm_bus_pkg::solver_cfg_t    cfg;
    admm_bus_pkg::solver_status_t status;
    logic                         start_req;
    admm_pkg::elem_param_t        elem_param;
    admm_pkg::idx_t               elem_sel;
    admm_pkg::idx_t               rd_idx;
    admm_pkg::idx_t               rb_idx;
    logic                         clear;
    admm_pkg::elem_req_t          req;
    logic                         req_valid;
    admm_pkg::elem_res_t          res;
    logic                         res_valid;
    admm_pkg::fixed_t             z_rd;
    admm_pkg::fixed_t             y_rd;
    admm_pkg::fixed_t             z_rb;
    admm_pkg::fixed_t             y_rb;

    admm_config_regs u_config_regs (
        .clk(clk), .rst(rst), .chipselect(chipselect), .write(write), .addr(addr),
        .writedata(writedata), .elem_sel(elem_sel), .cfg(cfg), .start_req(start_req),
        .elem_param(elem_param)
    );

    admm_iter_ctrl u_iter_ctrl (
        .clk(clk), .rst(rst), .cfg(cfg), .start_req(start_req), .elem_param(elem_param),
        .z_rd(z_rd), .y_rd(y_rd), .res(res), .res_valid(res_valid), .elem_sel(elem_sel),
        .rd_idx(rd_idx), .clear(clear), .req(req), .req_valid(req_valid), .status(status)
    );

    admm_element_pipe u_element_pipe (
        .clk(clk), .rst(rst), .req(req), .req_valid(req_valid),
        .res(res), .res_valid(res_valid)
    );

    // Writeback of z and y straight from the pipeline result
    admm_vector_store u_vector_store (
        .clk(clk), .rst(rst), .clear(clear), .rd_idx(rd_idx), .wr_valid(res_valid),
        .wr_idx(res.idx), .z_wr(res.z_new), .y_wr(res.y_new), .rb_idx(rb_idx),
        .z_rd(z_rd), .y_rd(y_rd), .z_rb(z_rb), .y_rb(y_rb)
    );

    admm_readback u_readback (
        .clk(clk), .rst(rst), .chipselect(chipselect), .read(read), .addr(addr),
        .status(status), .z_rb(z_rb), .y_rb(y_rb), .rb_idx(rb_idx), .readdata(readdata)
    );

endmodule

`default_nettype wire

//--- admm_readback.sv
`timescale 1ns/100ps
`default_nettype none

module admm_readback (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 chipselect,
    input  logic                                 read,
    input  logic [admm_bus_pkg::ADDR_WIDTH-1:0]  addr,
    input  admm_bus_pkg::solver_status_t         status,
    input  admm_pkg::fixed_t                     z_rb,
    input  admm_pkg::fixed_t                     y_rb,
    output admm_pkg::idx_t                       rb_idx,
    output logic [admm_bus_pkg::BUS_WIDTH-1:0]   readdata
);

    logic [admm_bus_pkg::BUS_WIDTH-1:0] rd_value;

    function automatic logic [admm_bus_pkg::BUS_WIDTH-1:0] sext(input admm_pkg::fixed_t v);
        return admm_bus_pkg::BUS_WIDTH'(v);
    endfunction

    assign rb_idx = addr[4:2];

    always_comb begin
        rd_value = '0;                               // Unmapped reads return 0
        case (admm_bus_pkg::region_t'(addr[15:12]))
            admm_bus_pkg::CTRL: begin
                case (addr[11:0])
                    admm_bus_pkg::OFS_START_STATUS:
                        rd_value[2:0] = {status.busy, status.converged, status.done};
                    admm_bus_pkg::OFS_MAXITER: rd_value[7:0] = status.iter;
                    admm_bus_pkg::OFS_PRI:     rd_value = sext(status.pri_res);
                    admm_bus_pkg::OFS_DUAL:    rd_value = sext(status.dual_res);
                    default: ;
                endcase
            end
            admm_bus_pkg::Z_OUT: rd_value = sext(z_rb);
            admm_bus_pkg::Y_OUT: rd_value = sext(y_rb);
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            readdata <= '0;
        else if (chipselect && read)
            readdata <= rd_value;                    // Holds between reads
    end

endmodule

`default_nettype wire

//--- admm_vector_store.sv
`timescale 1ns/100ps
`default_nettype none

module admm_vector_store (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  admm_pkg::idx_t    rd_idx,
    input  logic              wr_valid,
    input  admm_pkg::idx_t    wr_idx,
    input  admm_pkg::fixed_t  z_wr,
    input  admm_pkg::fixed_t  y_wr,
    input  admm_pkg::idx_t    rb_idx,
    output admm_pkg::fixed_t  z_rd,
    output admm_pkg::fixed_t  y_rd,
    output admm_pkg::fixed_t  z_rb,
    output admm_pkg::fixed_t  y_rb
);

    admm_pkg::fixed_t z_mem [admm_pkg::VEC_LEN];
    admm_pkg::fixed_t y_mem [admm_pkg::VEC_LEN];

    assign z_rd = z_mem[rd_idx];                     // Solver port
    assign y_rd = y_mem[rd_idx];
    assign z_rb = z_mem[rb_idx];                     // Bus readback port
    assign y_rb = y_mem[rb_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            z_mem <= '{default: '0};
            y_mem <= '{default: '0};
        end else if (clear) begin
            z_mem <= '{default: '0};                 // Fresh solve starts from zero
            y_mem <= '{default: '0};
        end else if (wr_valid) begin
            z_mem[wr_idx] <= z_wr;
            y_mem[wr_idx] <= y_wr;
        end
    end

    // Pipeline must be drained before a new start clears the vectors
    a_no_wr_on_clear: assert property (@(posedge clk) disable iff (rst)
        !(clear && wr_valid));

endmodule

`default_nettype wire

//--- admm_element_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module admm_element_pipe (
    input  logic                  clk,
    input  logic                  rst,
    input  admm_pkg::elem_req_t   req,
    input  logic                  req_valid,
    output admm_pkg::elem_res_t   res,
    output logic                  res_valid
);

    logic signed [admm_pkg::DATA_WIDTH+1:0] sum_x;   // Two guard bits
    logic signed [admm_pkg::DATA_WIDTH+1:0] sum_w;
    logic signed [admm_pkg::DATA_WIDTH+1:0] sum_y;
    admm_pkg::fixed_t w;
    admm_pkg::fixed_t z_new;

    logic             s1_valid;
    admm_pkg::idx_t   s1_idx;
    admm_pkg::fixed_t s1_x;
    admm_pkg::fixed_t s1_z;
    admm_pkg::fixed_t s1_y;
    admm_pkg::fixed_t s1_lo;
    admm_pkg::fixed_t s1_hi;

    function automatic admm_pkg::fixed_t sat(input logic signed [admm_pkg::DATA_WIDTH+1:0] v);
        if (v > admm_pkg::FIXED_MAX)
            return admm_pkg::FIXED_MAX;
        if (v < admm_pkg::FIXED_MIN)
            return admm_pkg::FIXED_MIN;
        return v[admm_pkg::DATA_WIDTH-1:0];
    endfunction

    function automatic admm_pkg::fixed_t sat_abs(input logic signed [admm_pkg::DATA_WIDTH+1:0] v);
        return sat((v < 0) ? -v : v);
    endfunction

    assign sum_x = req.ref_val + req.z - req.y;

    // Stage 2 datapath
    assign sum_w = s1_x + s1_y;
    assign w     = sat(sum_w);
    assign z_new = (w < s1_lo) ? s1_lo : ((w > s1_hi) ? s1_hi : w);  // Box projection
    assign sum_y = s1_y + s1_x - z_new;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= req_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx <= req.idx;
        s1_x   <= sat(sum_x) >>> 1;                  // rho = 1, floor halving
        s1_z   <= req.z;
        s1_y   <= req.y;
        s1_lo  <= req.lo;
        s1_hi  <= req.hi;

        res.idx       <= s1_idx;
        res.z_new     <= z_new;
        res.y_new     <= sat(sum_y);
        res.pri_term  <= sat_abs(s1_x - z_new);
        res.dual_term <= sat_abs(z_new - s1_z);
    end

    // Bounds come straight from bus-written registers
    a_bounds_ordered: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> req.lo <= req.hi);

endmodule

`default_nettype wire

//--- admm_iter_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module admm_iter_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  admm_bus_pkg::solver_cfg_t      cfg,
    input  logic                           start_req,
    input  admm_pkg::elem_param_t          elem_param,
    input  admm_pkg::fixed_t               z_rd,
    input  admm_pkg::fixed_t               y_rd,
    input  admm_pkg::elem_res_t            res,
    input  logic                           res_valid,
    output admm_pkg::idx_t                 elem_sel,
    output admm_pkg::idx_t                 rd_idx,
    output logic                           clear,
    output admm_pkg::elem_req_t            req,
    output logic                           req_valid,
    output admm_bus_pkg::solver_status_t   status
);

    admm_pkg::solver_state_t state;
    admm_pkg::idx_t          cnt;                    // Element being issued
    logic [7:0]              iter;
    logic                    converged;
    admm_pkg::fixed_t        pri_max;
    admm_pkg::fixed_t        dual_max;
    logic                    accept;
    logic                    last_res;
    logic                    met_tol;
    logic [7:0]              iter_next;

    assign accept    = start_req && (state == admm_pkg::IDLE || state == admm_pkg::DONE);
    assign clear     = accept;                       // Store clears at the SWEEP entry edge
    assign last_res  = res_valid && res.idx == admm_pkg::idx_t'(admm_pkg::VEC_LEN - 1);
    assign met_tol   = pri_max <= cfg.pri_tol && dual_max <= cfg.dual_tol;
    assign iter_next = iter + 8'd1;

    assign elem_sel  = cnt;
    assign rd_idx    = cnt;
    assign req_valid = (state == admm_pkg::SWEEP);
    assign req.idx     = cnt;
    assign req.ref_val = elem_param.ref_val;
    assign req.lo      = elem_param.lo;
    assign req.hi      = elem_param.hi;
    assign req.z       = z_rd;
    assign req.y       = y_rd;

    assign status.busy      = state inside {admm_pkg::SWEEP, admm_pkg::DRAIN, admm_pkg::CHECK};
    assign status.done      = (state == admm_pkg::DONE);
    assign status.converged = converged;
    assign status.iter      = iter;
    assign status.pri_res   = pri_max;
    assign status.dual_res  = dual_max;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= admm_pkg::IDLE;
            cnt       <= '0;
            iter      <= '0;
            converged <= 1'b0;
            pri_max   <= '0;
            dual_max  <= '0;
        end else begin
            if (res_valid) begin                     // Running maxima of the terms
                if (res.pri_term > pri_max)
                    pri_max <= res.pri_term;
                if (res.dual_term > dual_max)
                    dual_max <= res.dual_term;
            end
            case (state)
                admm_pkg::IDLE, admm_pkg::DONE: begin
                    if (accept) begin
                        state     <= admm_pkg::SWEEP;
                        cnt       <= '0;
                        iter      <= '0;
                        converged <= 1'b0;
                        pri_max   <= '0;
                        dual_max  <= '0;
                    end
                end
                admm_pkg::SWEEP: begin
                    cnt <= cnt + 1'b1;               // Wraps to 0 for the next sweep
                    if (cnt == admm_pkg::idx_t'(admm_pkg::VEC_LEN - 1))
                        state <= admm_pkg::DRAIN;
                end
                admm_pkg::DRAIN: begin
                    if (last_res)
                        state <= admm_pkg::CHECK;
                end
                admm_pkg::CHECK: begin
                    iter <= iter_next;
                    if (met_tol) begin
                        state     <= admm_pkg::DONE;
                        converged <= 1'b1;
                    end else if (iter_next >= cfg.max_iter) begin
                        state <= admm_pkg::DONE;     // Iteration cap
                    end else begin
                        state    <= admm_pkg::SWEEP;
                        pri_max  <= '0;
                        dual_max <= '0;
                    end
                end
                default: state <= admm_pkg::IDLE;
            endcase
        end
    end

    // Pipeline results only return while a sweep issues or drains
    a_res_in_sweep: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> state inside {admm_pkg::SWEEP, admm_pkg::DRAIN});

endmodule

`default_nettype wire

//--- admm_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module admm_config_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  chipselect,
    input  logic                                  write,
    input  logic [admm_bus_pkg::ADDR_WIDTH-1:0]   addr,
    input  logic [admm_bus_pkg::BUS_WIDTH-1:0]    writedata,
    input  admm_pkg::idx_t                        elem_sel,
    output admm_bus_pkg::solver_cfg_t             cfg,
    output logic                                  start_req,
    output admm_pkg::elem_param_t                 elem_param
);

    admm_bus_pkg::region_t region;
    logic [11:0]           offset;
    admm_pkg::idx_t        idx;
    logic                  wr_en;
    admm_pkg::fixed_t      wdata;

    admm_pkg::elem_param_t params [admm_pkg::VEC_LEN];

    assign wr_en  = chipselect && write;
    assign region = admm_bus_pkg::region_t'(addr[15:12]);
    assign offset = addr[11:0];
    assign idx    = addr[4:2];                       // Word index in vector regions
    assign wdata  = writedata[admm_pkg::DATA_WIDTH-1:0];

    assign elem_param = params[elem_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.max_iter <= admm_bus_pkg::DEF_MAX_ITER;
            cfg.pri_tol  <= admm_bus_pkg::DEF_TOL;
            cfg.dual_tol <= admm_bus_pkg::DEF_TOL;
            start_req    <= 1'b0;
            for (int i = 0; i < admm_pkg::VEC_LEN; i++) begin
                params[i].ref_val <= admm_bus_pkg::DEF_REF;
                params[i].lo      <= admm_bus_pkg::DEF_LO;
                params[i].hi      <= admm_bus_pkg::DEF_HI;
            end
        end else begin
            // One-cycle pulse, ctrl decides whether to accept it
            start_req <= wr_en && region == admm_bus_pkg::CTRL &&
                         offset == admm_bus_pkg::OFS_START_STATUS && writedata[0];
            if (wr_en) begin
                case (region)
                    admm_bus_pkg::CTRL: begin
                        case (offset)
                            admm_bus_pkg::OFS_MAXITER: cfg.max_iter <= writedata[7:0];
                            admm_bus_pkg::OFS_PRI:     cfg.pri_tol  <= wdata;
                            admm_bus_pkg::OFS_DUAL:    cfg.dual_tol <= wdata;
                            default: ;
                        endcase
                    end
                    admm_bus_pkg::REF: params[idx].ref_val <= wdata;
                    admm_bus_pkg::LO:  params[idx].lo      <= wdata;
                    admm_bus_pkg::HI:  params[idx].hi      <= wdata;
                    default: ;                       // Read-only or unmapped
                endcase
            end
        end
    end

    // Bus strobes are single-cycle, so a start never stretches
    a_start_pulse: assert property (@(posedge clk) disable iff (rst)
        start_req |=> !start_req);

endmodule

`default_nettype wire

//--- admm_bus_pkg.sv
`default_nettype none

package admm_bus_pkg;

    localparam int BUS_WIDTH  = 32;
    localparam int ADDR_WIDTH = 16;

    // Region select on addr[15:12]
    typedef enum logic [3:0] {
        CTRL  = 4'h0,
        REF   = 4'h1,
        LO    = 4'h2,
        HI    = 4'h3,
        Z_OUT = 4'h4,
        Y_OUT = 4'h5
    } region_t;

    // Offsets inside the control region
    localparam logic [11:0] OFS_START_STATUS = 12'h000;
    localparam logic [11:0] OFS_MAXITER      = 12'h004;    // Reads back iter
    localparam logic [11:0] OFS_PRI          = 12'h008;
    localparam logic [11:0] OFS_DUAL         = 12'h00C;

    localparam logic [7:0]       DEF_MAX_ITER = 8'd100;
    localparam admm_pkg::fixed_t DEF_TOL      = 16'sd2;     // Two LSBs
    localparam admm_pkg::fixed_t DEF_REF      = '0;
    localparam admm_pkg::fixed_t DEF_LO       = admm_pkg::FIXED_MIN;
    localparam admm_pkg::fixed_t DEF_HI       = admm_pkg::FIXED_MAX;

    typedef struct packed {
        logic [7:0]       max_iter;
        admm_pkg::fixed_t pri_tol;
        admm_pkg::fixed_t dual_tol;
    } solver_cfg_t;

    typedef struct packed {
        logic             busy;
        logic             done;
        logic             converged;
        logic [7:0]       iter;
        admm_pkg::fixed_t pri_res;               // Max primal term of last sweep
        admm_pkg::fixed_t dual_res;
    } solver_status_t;

endpackage

`default_nettype wire

//--- admm_pkg.sv
`default_nettype none

package admm_pkg;

    localparam int DATA_WIDTH = 16;              // Q8.8 signed values
    localparam int FRAC_BITS  = 8;
    localparam int VEC_LEN    = 8;
    localparam int IDX_WIDTH  = 3;

    typedef logic signed [DATA_WIDTH-1:0] fixed_t;
    typedef logic [IDX_WIDTH-1:0] idx_t;

    localparam fixed_t FIXED_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam fixed_t FIXED_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};

    // Per-element problem data as held in the config registers
    typedef struct packed {
        fixed_t ref_val;
        fixed_t lo;
        fixed_t hi;
    } elem_param_t;

    typedef struct packed {
        idx_t   idx;
        fixed_t ref_val;
        fixed_t lo;
        fixed_t hi;
        fixed_t z;                               // Slack from previous sweep
        fixed_t y;                               // Dual from previous sweep
    } elem_req_t;

    typedef struct packed {
        idx_t   idx;
        fixed_t z_new;
        fixed_t y_new;
        fixed_t pri_term;                        // |x - z_new|
        fixed_t dual_term;                       // |z_new - z|
    } elem_res_t;

    typedef enum logic [2:0] {
        IDLE,
        SWEEP,
        DRAIN,
        CHECK,
        DONE
    } solver_state_t;

endpackage

`default_nettype wire
